// File: bp_config.svh
`ifndef BP_CONFIG_SVH
`define BP_CONFIG_SVH

//////////////////////////////////////////////////
// layer geometry
//////////////////////////////////////////////////

// neurons per layer, also rows and columns of w
`define BP_NEURON_NUM      4
// bits needed to pick one row
`define BP_ROW_IDX_WIDTH   2

//////////////////////////////////////////////////
// fixed-point formats
//////////////////////////////////////////////////

`define BP_Z_WIDTH         10
`define BP_ACT_WIDTH       9
`define BP_DELTA_WIDTH     10
`define BP_WEIGHT_WIDTH    16
`define BP_FRACTION_WIDTH  8
`define BP_LR_WIDTH        3
// 0..15 weights row-major, 16 the shift
`define BP_CFG_ADDR_WIDTH  5

`endif

// File: bp_num_pkg.sv
`include "bp_config.svh"

package bp_num_pkg;

    // pre-activation out of the layer, signed
    // 8 fraction bits
    typedef logic signed [`BP_Z_WIDTH-1:0] z_t;

    // unsigned activation, 256 is one
    typedef logic [`BP_ACT_WIDTH-1:0] act_t;

    // per-neuron error term
    typedef logic signed [`BP_DELTA_WIDTH-1:0] delta_t;

    // one cell of the weight matrix
    typedef logic signed [`BP_WEIGHT_WIDTH-1:0] weight_t;

    // extra right shift applied to the gradient
    typedef logic [`BP_LR_WIDTH-1:0] lr_shift_t;

    // config port address
    typedef logic [`BP_CFG_ADDR_WIDTH-1:0] cfg_addr_t;

    // row of the weight matrix
    typedef logic [`BP_ROW_IDX_WIDTH-1:0] row_idx_t;

endpackage

// File: bp_ctrl_pkg.sv
`include "bp_config.svh"

package bp_ctrl_pkg;

    import bp_num_pkg::*;

    // updater sequencing
    typedef enum logic [1:0] {IDLE, ROW, DONE} updater_state_e;

    // one training sample, 116 bits
    typedef struct packed {
        z_t   [`BP_NEURON_NUM-1:0] z;
        act_t [`BP_NEURON_NUM-1:0] target;
        z_t   [`BP_NEURON_NUM-1:0] z_prev;
    } sample_s;

    // deltas plus previous activations, 76 bits
    typedef struct packed {
        delta_t [`BP_NEURON_NUM-1:0] delta;
        act_t   [`BP_NEURON_NUM-1:0] a_prev;
    } grad_s;

    // one updated row toward the bank
    typedef struct packed {
        row_idx_t                     row;
        weight_t [`BP_NEURON_NUM-1:0] w;
        logic                         sat;
    } row_write_s;

    // full matrix, index is row * N + col
    typedef struct packed {
        weight_t [`BP_NEURON_NUM*`BP_NEURON_NUM-1:0] w;
    } weight_matrix_s;

endpackage

// File: error_fetcher.sv
`include "bp_config.svh"

module error_fetcher
    import bp_num_pkg::*, bp_ctrl_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  sample_s sample,
    input  logic    sample_valid,
    output logic    sample_ready,
    output grad_s   grad,
    output logic    grad_valid,
    input  logic    grad_ready
);

    localparam int N = `BP_NEURON_NUM;

    // one extra bit so z/4 + 0.5 never wraps
    typedef logic signed [`BP_Z_WIDTH:0] z_ext_t;
    // a - target and its product with sigma'
    typedef logic signed [`BP_ACT_WIDTH+1:0] diff_t;
    typedef logic signed [2*`BP_ACT_WIDTH+2:0] err_prod_t;

    localparam z_ext_t ACT_HALF = z_ext_t'(1 << (`BP_FRACTION_WIDTH - 1));
    localparam z_ext_t ACT_ONE = z_ext_t'(1 << `BP_FRACTION_WIDTH);
    // slope of the linear band, 0.25
    localparam act_t DERIV_LIN = act_t'(1 << (`BP_FRACTION_WIDTH - 2));

    // clamp z/4 + 0.5 into the range 0 to 1
    function automatic act_t hard_sigmoid(input z_t z);
        z_ext_t sum;
        act_t   a;
        sum = z_ext_t'(z >>> 2) + ACT_HALF;
        if (sum <= 0) begin
            a = '0;
        end else if (sum >= ACT_ONE) begin
            a = act_t'(ACT_ONE);
        end else begin
            a = act_t'(sum);
        end
        return a;
    endfunction

    logic         s1_valid;
    act_t [N-1:0] s1_act;
    act_t [N-1:0] s1_act_prev;
    act_t [N-1:0] s1_target;
    // set where the clamp left z alone
    logic [N-1:0] s1_lin;

    act_t [N-1:0]   act_d;
    act_t [N-1:0]   act_prev_d;
    logic [N-1:0]   lin_d;
    delta_t [N-1:0] delta_d;

    logic s2_valid;
    logic s2_take;

    //////////////////////////////////////////////////
    // handshake
    //////////////////////////////////////////////////

    // stage 2 moves when empty or drained this cycle
    assign s2_take      = !s2_valid || grad_ready;
    // low only with both stages full and stalled
    assign sample_ready = !s1_valid || s2_take;
    assign grad_valid   = s2_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            if (sample_ready) begin
                s1_valid <= sample_valid;
            end
            if (s2_take) begin
                s2_valid <= s1_valid;
            end
        end
    end

    //////////////////////////////////////////////////
    // stage 1, activations and clamp flags
    //////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < N; i++) begin
            act_d[i]      = hard_sigmoid(sample.z[i]);
            act_prev_d[i] = hard_sigmoid(sample.z_prev[i]);
            // a clamped value sits exactly on 0 or 1
            lin_d[i]      = (act_d[i] != '0) && (act_d[i] != act_t'(ACT_ONE));
        end
    end

    always_ff @(posedge clk) begin
        if (sample_valid && sample_ready) begin
            s1_act      <= act_d;
            s1_act_prev <= act_prev_d;
            s1_target   <= sample.target;
            s1_lin      <= lin_d;
        end
    end

    //////////////////////////////////////////////////
    // stage 2, deltas
    //////////////////////////////////////////////////

    always_comb begin
        diff_t     diff;
        act_t      deriv;
        err_prod_t prod;
        for (int i = 0; i < N; i++) begin
            deriv      = s1_lin[i] ? DERIV_LIN : '0;
            diff       = diff_t'(s1_act[i]) - diff_t'(s1_target[i]);
            // (a - t) * sigma', back to 8 fraction bits
            prod       = err_prod_t'(diff) * err_prod_t'(deriv);
            delta_d[i] = delta_t'(prod >>> `BP_FRACTION_WIDTH);
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid && s2_take) begin
            grad.delta  <= delta_d;
            grad.a_prev <= s1_act_prev;
        end
    end

endmodule

// File: weight_updater.sv
`include "bp_config.svh"

module weight_updater
    import bp_num_pkg::*, bp_ctrl_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  grad_s          grad,
    input  logic           grad_valid,
    output logic           grad_ready,
    input  weight_matrix_s weights,
    input  lr_shift_t      lr_shift,
    output row_write_s     row_write,
    output logic           row_write_en,
    output logic           weights_valid,
    input  logic           weights_ready
);

    localparam int N = `BP_NEURON_NUM;
    localparam row_idx_t LAST_ROW = row_idx_t'(N - 1);

    // delta times zero-extended activation
    typedef logic signed [`BP_DELTA_WIDTH+`BP_ACT_WIDTH:0] prod_t;
    // weight minus step, one guard bit
    typedef logic signed [`BP_WEIGHT_WIDTH:0] wsum_t;

    localparam wsum_t W_MAX = wsum_t'((1 << (`BP_WEIGHT_WIDTH - 1)) - 1);
    localparam wsum_t W_MIN = wsum_t'(-(1 << (`BP_WEIGHT_WIDTH - 1)));

    updater_state_e state;
    row_idx_t       row;
    grad_s          grad_q;
    row_write_s     row_d;

    assign grad_ready = (state == IDLE);
    // wait for the last row to land in the bank
    assign weights_valid = (state == DONE) && !row_write_en;

    //////////////////////////////////////////////////
    // sequencing
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= IDLE;
            row          <= '0;
            row_write_en <= 1'b0;
        end else begin
            // strobe follows each ROW cycle
            row_write_en <= (state == ROW);
            case (state)
                IDLE: begin
                    if (grad_valid) begin
                        state <= ROW;
                        row   <= '0;
                    end
                end
                ROW: begin
                    // wraps back to 0 after the last row
                    row <= row + row_idx_t'(1);
                    if (row == LAST_ROW) begin
                        state <= DONE;
                    end
                end
                DONE: begin
                    if (weights_valid && weights_ready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // row update
    //////////////////////////////////////////////////

    // w[row][j] -= (delta[row] * a_prev[j]) >>> (8 + shift)
    always_comb begin
        prod_t prod;
        wsum_t diff;
        row_d.row = row;
        row_d.sat = 1'b0;
        for (int j = 0; j < N; j++) begin
            prod = prod_t'(grad_q.delta[row]) * prod_t'(grad_q.a_prev[j]);
            prod = prod >>> (`BP_FRACTION_WIDTH + lr_shift);
            diff = wsum_t'(weights.w[row * N + j]) - wsum_t'(prod);
            // clip to the weight range and flag it
            if (diff > W_MAX) begin
                row_d.w[j] = weight_t'(W_MAX);
                row_d.sat  = 1'b1;
            end else if (diff < W_MIN) begin
                row_d.w[j] = weight_t'(W_MIN);
                row_d.sat  = 1'b1;
            end else begin
                row_d.w[j] = weight_t'(diff);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grad_valid && grad_ready) begin
            grad_q <= grad;
        end
        if (state == ROW) begin
            row_write <= row_d;
        end
    end

endmodule

// File: weight_bank.sv
`include "bp_config.svh"

module weight_bank
    import bp_num_pkg::*, bp_ctrl_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  logic           cfg_write,
    input  cfg_addr_t      cfg_addr,
    input  weight_t        cfg_data,
    input  row_write_s     row_write,
    input  logic           row_write_en,
    output weight_matrix_s weights,
    output lr_shift_t      lr_shift,
    output logic           error
);

    localparam int N = `BP_NEURON_NUM;
    // row and column bits of a weight address
    localparam int CELL_IDX_WIDTH = 2 * `BP_ROW_IDX_WIDTH;
    // first address past the matrix holds the shift
    localparam cfg_addr_t LR_ADDR = cfg_addr_t'(N * N);

    //////////////////////////////////////////////////
    // weights and shift
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            weights  <= '0;
            lr_shift <= '0;
        end else begin
            if (cfg_write) begin
                if (cfg_addr < LR_ADDR) begin
                    weights.w[cfg_addr[CELL_IDX_WIDTH-1:0]] <= cfg_data;
                end else if (cfg_addr == LR_ADDR) begin
                    lr_shift <= cfg_data[`BP_LR_WIDTH-1:0];
                end
            end
            // a whole row per strobe
            if (row_write_en) begin
                for (int j = 0; j < N; j++) begin
                    weights.w[{row_write.row, row_idx_t'(j)}] <= row_write.w[j];
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // sticky saturation flag
    //////////////////////////////////////////////////

    // any config write clears it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            error <= 1'b0;
        end else if (cfg_write) begin
            error <= 1'b0;
        end else if (row_write_en && row_write.sat) begin
            error <= 1'b1;
        end
    end

endmodule

// File: backpropagator.sv
module backpropagator
    import bp_num_pkg::*, bp_ctrl_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  sample_s        sample,
    input  logic           sample_valid,
    output logic           sample_ready,
    output weight_matrix_s weights,
    output logic           weights_valid,
    input  logic           weights_ready,
    input  logic           cfg_write,
    input  cfg_addr_t      cfg_addr,
    input  weight_t        cfg_data,
    output logic           error
);

    // fetcher to updater
    grad_s      grad;
    logic       grad_valid;
    logic       grad_ready;

    // updater to bank
    row_write_s row_write;
    logic       row_write_en;
    lr_shift_t  lr_shift;

    error_fetcher error_fetcher_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample       (sample),
        .sample_valid (sample_valid),
        .sample_ready (sample_ready),
        .grad         (grad),
        .grad_valid   (grad_valid),
        .grad_ready   (grad_ready)
    );

    weight_updater weight_updater_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .grad          (grad),
        .grad_valid    (grad_valid),
        .grad_ready    (grad_ready),
        .weights       (weights),
        .lr_shift      (lr_shift),
        .row_write     (row_write),
        .row_write_en  (row_write_en),
        .weights_valid (weights_valid),
        .weights_ready (weights_ready)
    );

    // bank matrix doubles as the weights output
    weight_bank weight_bank_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_write    (cfg_write),
        .cfg_addr     (cfg_addr),
        .cfg_data     (cfg_data),
        .row_write    (row_write),
        .row_write_en (row_write_en),
        .weights      (weights),
        .lr_shift     (lr_shift),
        .error        (error)
    );

endmodule

// File: backprop_assertions.sv
module backprop_assertions
    import bp_num_pkg::*, bp_ctrl_pkg::*;
(
    input logic           clk,
    input logic           rst_n,
    input logic           sample_valid,
    input logic           sample_ready,
    input sample_s        sample,
    input logic           grad_valid,
    input logic           grad_ready,
    input grad_s          grad,
    input logic           weights_valid,
    input logic           weights_ready,
    input weight_matrix_s weights,
    input logic           cfg_write
);

    timeunit 1ns;
    timeprecision 1ps;

    //////////////////////////////////////////////////
    // valid held with a stable payload until ready
    //////////////////////////////////////////////////

    a_sample_hold: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid && !sample_ready |=> sample_valid && $stable(sample))
        else $error("sample dropped or changed before ready");

    a_grad_hold: assert property (@(posedge clk) disable iff (!rst_n)
        grad_valid && !grad_ready |=> grad_valid && $stable(grad))
        else $error("grad dropped or changed before ready");

    a_weights_hold: assert property (@(posedge clk) disable iff (!rst_n)
        weights_valid && !weights_ready |=> weights_valid && $stable(weights))
        else $error("weights dropped or changed before ready");

    // outputs quiet while in reset
    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !weights_valid && !grad_valid)
        else $error("valid high during reset");

    // config only between updates with the updater idle
    a_cfg_idle: assert property (@(posedge clk) disable iff (!rst_n)
        cfg_write |-> !weights_valid && grad_ready)
        else $error("config write while weights are presented or the updater is busy");

endmodule

bind backpropagator backprop_assertions backprop_assertions_i (.*);

// File: tb_backpropagator.sv
module tb_backpropagator
    import bp_num_pkg::*, bp_ctrl_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct {
        bit      is_cfg;
        bit      stall;
        int      addr;
        int      data;
        sample_s smp;
    } entry_t;

    logic           clk;
    logic           rst_n;
    sample_s        sample;
    logic           sample_valid;
    logic           sample_ready;
    weight_matrix_s weights;
    logic           weights_valid;
    logic           weights_ready;
    logic           cfg_write;
    cfg_addr_t      cfg_addr;
    weight_t        cfg_data;
    logic           error;

    entry_t         table_q[$];
    weight_matrix_s exp_w_q[$];
    bit             exp_err_q[$];
    bit             lat_q[$];
    int             hs_q[$];
    int             ref_w[16];
    int             ref_shift;
    bit             ref_err;
    bit             stall_mode;
    bit             prev_valid;
    int             cycle_cnt;
    int             limit;
    int             checks;
    int             errors;

    backpropagator backpropagator_i (.*);

    always #4 clk = ~clk;

    //////////////////////////////////////////////////
    // checks and reference model
    //////////////////////////////////////////////////

    task automatic compare(input string what, input longint got, input longint exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("ERROR @%0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    // hard sigmoid where v strictly inside 0..256 is the linear band
    function automatic int activation(input int z);
        int v;
        v = (z >>> 2) + 128;
        if (v < 0) v = 0;
        if (v > 256) v = 256;
        return v;
    endfunction

    // one training step on ref_w returning the new matrix
    function automatic weight_matrix_s train(input sample_s s, output bit sat);
        weight_matrix_s m;
        int a;
        int d[4];
        int ap[4];
        int nw;
        sat = 1'b0;
        for (int i = 0; i < 4; i++) begin
            a = activation(int'(s.z[i]));
            ap[i] = activation(int'(s.z_prev[i]));
            d[i] = (a > 0 && a < 256) ? ((a - int'(s.target[i])) >>> 2) : 0;
        end
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                nw = ref_w[i*4+j] - ((d[i] * ap[j]) >>> (8 + ref_shift));
                if (nw > 32767) begin
                    nw = 32767;
                    sat = 1'b1;
                end else if (nw < -32768) begin
                    nw = -32768;
                    sat = 1'b1;
                end
                ref_w[i*4+j] = nw;
                m.w[i*4+j] = weight_t'(nw);
            end
        end
        return m;
    endfunction

    function automatic sample_s build_sample(input int z0, z1, z2, z3,
                                             input int t0, t1, t2, t3,
                                             input int p0, p1, p2, p3);
        sample_s s;
        s.z      = {z_t'(z3), z_t'(z2), z_t'(z1), z_t'(z0)};
        s.target = {act_t'(t3), act_t'(t2), act_t'(t1), act_t'(t0)};
        s.z_prev = {z_t'(p3), z_t'(p2), z_t'(p1), z_t'(p0)};
        return s;
    endfunction

    task automatic add_cfg(input int addr, input int data);
        entry_t e;
        e.is_cfg = 1'b1;
        e.stall  = 1'b0;
        e.addr   = addr;
        e.data   = data;
        e.smp    = '0;
        table_q.push_back(e);
    endtask

    task automatic add_sample(input sample_s s, input bit stall);
        entry_t e;
        e.is_cfg = 1'b0;
        e.stall  = stall;
        e.addr   = 0;
        e.data   = 0;
        e.smp    = s;
        table_q.push_back(e);
    endtask

    //////////////////////////////////////////////////
    // drivers
    //////////////////////////////////////////////////

    task automatic apply_cfg(input int addr, input int data);
        do @(negedge clk); while (exp_w_q.size() != 0 || weights_valid);
        @(posedge clk);
        @(posedge clk);
        cfg_write <= 1'b1;
        cfg_addr  <= cfg_addr_t'(addr);
        cfg_data  <= weight_t'(data);
        @(posedge clk);
        cfg_write <= 1'b0;
        if (addr < 16) ref_w[addr] = int'(weight_t'(data));
        else ref_shift = data & 7;
        ref_err = 1'b0;
        @(negedge clk);
        compare("error after config write", error, 0);
    endtask

    task automatic apply_sample(input sample_s s, input bit stall);
        bit sat;
        if (!stall) begin
            do @(negedge clk); while (exp_w_q.size() != 0);
        end
        @(posedge clk);
        sample       <= s;
        sample_valid <= 1'b1;
        do @(negedge clk); while (!sample_ready);
        // latency only measured on an empty pipe
        lat_q.push_back(!stall && exp_w_q.size() == 0);
        hs_q.push_back(cycle_cnt);
        exp_w_q.push_back(train(s, sat));
        ref_err = ref_err | sat;
        exp_err_q.push_back(ref_err);
        @(posedge clk);
        sample_valid <= 1'b0;
    endtask

    always @(posedge clk) begin
        cycle_cnt     <= cycle_cnt + 1;
        weights_ready <= stall_mode ? 1'($urandom % 2) : 1'b1;
        if (cycle_cnt >= limit) begin
            $display("timeout: no result after %0d cycles", cycle_cnt);
            $display("** FAIL **");
            $finish;
        end
    end

    // output monitor sampled mid-cycle
    always @(negedge clk) begin
        weight_matrix_s m;
        int hs;
        if (rst_n) begin
            if (weights_valid && !prev_valid && lat_q.size() != 0 && lat_q[0]) begin
                compare("weights_valid latency", cycle_cnt - hs_q[0] - 1, 7);
            end
            if (weights_valid && weights_ready) begin
                if (exp_w_q.size() == 0) begin
                    errors++;
                    $display("unexpected weights output with no sample pending");
                end else begin
                    m  = exp_w_q.pop_front();
                    hs = hs_q.pop_front();
                    void'(lat_q.pop_front());
                    for (int k = 0; k < 16; k++) begin
                        compare($sformatf("w[%0d] of sample at cycle %0d", k, hs),
                                weights.w[k], m.w[k]);
                    end
                    compare("error flag", error, exp_err_q.pop_front());
                end
            end
        end
        prev_valid = weights_valid;
    end

    //////////////////////////////////////////////////
    // stimulus table and main sequence
    //////////////////////////////////////////////////

    initial begin
        void'($urandom(32'hcffc));
        clk = 1'b0;
        rst_n = 1'b0;
        sample = '0;
        sample_valid = 1'b0;
        weights_ready = 1'b0;
        cfg_write = 1'b0;
        cfg_addr = '0;
        cfg_data = '0;
        stall_mode = 1'b0;
        prev_valid = 1'b0;
        cycle_cnt = 0;
        limit = 1000000;
        checks = 0;
        errors = 0;
        ref_w = '{default: 0};
        ref_shift = 0;
        ref_err = 1'b0;

        // load all weights and the shift then run a zero-delta sample
        for (int k = 0; k < 16; k++) add_cfg(k, k * 100 - 700);
        add_cfg(16, 0);
        add_sample(build_sample(0, 0, 0, 0, 128, 128, 128, 128, 200, -100, 0, 300), 0);
        // linear range with shift 0 and 3
        add_sample(build_sample(40, -60, 100, -20, 100, 200, 50, 150, 200, -100, 0, 300), 0);
        add_cfg(16, 3);
        add_sample(build_sample(40, -60, 100, -20, 100, 200, 50, 150, 200, -100, 0, 300), 0);
        // row 2 clamped low
        add_sample(build_sample(300, -200, -512, 80, 10, 250, 0, 60, 400, 150, -300, 50), 0);
        // row 0 pushed under the weight range
        for (int k = 0; k < 4; k++) add_cfg(k, -32760);
        add_cfg(16, 0);
        add_sample(build_sample(300, 0, 0, 0, 0, 128, 128, 128, 400, 400, 400, 400), 0);
        add_cfg(5, 1234);
        // back-to-back under random stalls
        for (int n = 0; n < 8; n++) begin
            add_sample(build_sample(int'($urandom % 1001) - 500, int'($urandom % 1001) - 500,
                                    int'($urandom % 1001) - 500, int'($urandom % 1001) - 500,
                                    int'($urandom % 257), int'($urandom % 257),
                                    int'($urandom % 257), int'($urandom % 257),
                                    int'($urandom % 1001) - 500, int'($urandom % 1001) - 500,
                                    int'($urandom % 1001) - 500, int'($urandom % 1001) - 500),
                       1);
        end
        limit = 40 * table_q.size() + 100;

        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        compare("sample_ready after reset", sample_ready, 1);
        compare("weights_valid after reset", weights_valid, 0);
        compare("error after reset", error, 0);
        for (int k = 0; k < 16; k++) begin
            compare($sformatf("w[%0d] after reset", k), weights.w[k], 0);
        end

        foreach (table_q[n]) begin
            stall_mode = table_q[n].stall;
            if (table_q[n].is_cfg) apply_cfg(table_q[n].addr, table_q[n].data);
            else apply_sample(table_q[n].smp, table_q[n].stall);
        end
        do @(negedge clk); while (exp_w_q.size() != 0);
        repeat (2) @(posedge clk);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+.
bp_num_pkg.sv
bp_ctrl_pkg.sv
error_fetcher.sv
weight_updater.sv
weight_bank.sv
backpropagator.sv
backprop_assertions.sv
tb_backpropagator.sv

// File: Makefile
# Verilator simulation of the backpropagator
VERILATOR ?= verilator
TOP       ?= tb_backpropagator
FLAGS     ?= --binary --timing --assert -j 0
OBJ_DIR   ?= obj_dir
FILELIST  ?= sim.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf $(OBJ_DIR)
